/* all.f */
+incdir+.
blk_pkg.sv
cost_pkg.sv
blk_row_packer.sv
blk_fifo.sv
hadamard_wcost.sv
cost_min_select.sv
blk_cost_top.sv
tb_blk_cost_top.sv

/* blk_consts.svh */
// Block-cost engine constants
// Pixel, weight and cost widths, block geometry, group size and FIFO depth

`ifndef BLK_CONSTS_SVH
`define BLK_CONSTS_SVH

// ---------------------------------------------------------------------------
// Pixel side
// ---------------------------------------------------------------------------
`define BLK_PIX_W       8
// Edge of the square block, 16 positions in all
`define BLK_N           4
// Candidates compared per group
`define BLK_CAND_N      4
`define BLK_FIFO_DEPTH  4

// ---------------------------------------------------------------------------
// Cost side
// ---------------------------------------------------------------------------
// Signed per-position weight
`define BLK_WEIGHT_W    16
`define BLK_COST_W      32

`endif

/* blk_cost_top.sv */
// Block-cost engine top level
// Row packer feeds the block FIFO, the selector drains it and reports group minima

`timescale 1ns/100ps

module blk_cost_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  row_stb_i,
    input  blk_pkg::pix_row_t     row_i,
    input  cost_pkg::weight_set_t weights_i,
    input  logic                  stall_i,
    output logic                  blk_full_o,
    output logic                  blk_overflow_o,
    output logic                  best_vld_o,
    output blk_pkg::cand_idx_t    best_idx_o,
    output cost_pkg::cost_t       best_cost_o
);

    logic                push;
    blk_pkg::blk_entry_t push_entry;
    logic                pop;
    blk_pkg::blk_entry_t head_entry;
    logic                fifo_empty;

    blk_row_packer u_blk_row_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_stb_i (row_stb_i),
        .row_i     (row_i),
        .push_o    (push),
        .entry_o   (push_entry)
    );

    // Full goes out so the source can hold off
    blk_fifo #(
        .T (blk_pkg::blk_entry_t)
    ) u_blk_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_i     (push),
        .data_i     (push_entry),
        .pop_i      (pop),
        .data_o     (head_entry),
        .full_o     (blk_full_o),
        .empty_o    (fifo_empty),
        .overflow_o (blk_overflow_o)
    );

    cost_min_select u_cost_min_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .empty_i     (fifo_empty),
        .head_i      (head_entry),
        .weights_i   (weights_i),
        .pop_o       (pop),
        .best_vld_o  (best_vld_o),
        .best_idx_o  (best_idx_o),
        .best_cost_o (best_cost_o)
    );

endmodule

/* blk_fifo.sv */
// Show-ahead FIFO with a type-parameter payload
// Full and empty are levels, a push while full is dropped and flagged

`timescale 1ns/100ps

`include "blk_consts.svh"

module blk_fifo #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output T     data_o,
    output logic full_o,
    output logic empty_o,
    output logic overflow_o
);

    localparam int unsigned DEPTH = `BLK_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;
    logic             ovf_q;

    assign full_o  = (count == CNT_FULL);
    assign empty_o = (count == '0);
    assign wr_en   = push_i && !full_o;
    assign rd_en   = pop_i && !empty_o;

    // ---------------------------------------------------------------------------
    // Pointers and occupancy
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_q <= 1'b0;
        end else if (push_i && full_o) begin
            ovf_q <= 1'b1;
        end
    end

    // Head entry is visible whenever the FIFO is not empty
    assign data_o     = mem[rd_ptr];
    assign overflow_o = ovf_q;

endmodule

/* blk_pkg.sv */
// Pixel-side types of the block-cost engine
// Pixels, rows, whole blocks and the tagged entry held by the FIFO

package blk_pkg;

    `include "blk_consts.svh"

    // One unsigned pixel
    typedef logic [`BLK_PIX_W-1:0] pixel_t;

    // Position 0 sits in the lowest lane
    typedef pixel_t [`BLK_N-1:0] pix_row_t;

    // Raster order, pixel k is row k/4 and column k%4
    typedef pix_row_t [`BLK_N-1:0] pix_blk_t;

    // Candidate number within a group
    typedef logic [$clog2(`BLK_CAND_N)-1:0] cand_idx_t;

    // Finished block with its candidate tag
    typedef struct packed {
        pix_blk_t  blk;
        cand_idx_t idx;
    } blk_entry_t;

endpackage

/* blk_row_packer.sv */
// Row packer
// Collects four row strobes into one block, tags it and pushes it

`timescale 1ns/100ps

`include "blk_consts.svh"

module blk_row_packer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  row_stb_i,
    input  blk_pkg::pix_row_t     row_i,
    output logic                  push_o,
    output blk_pkg::blk_entry_t   entry_o
);

    localparam int unsigned ROW_W = $clog2(`BLK_N);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`BLK_N - 1);
    localparam blk_pkg::cand_idx_t TAG_LAST = blk_pkg::cand_idx_t'(`BLK_CAND_N - 1);

    logic [ROW_W-1:0]     row_cnt;
    blk_pkg::pix_blk_t    blk_q;
    blk_pkg::cand_idx_t   tag_q;
    logic                 push_q;

    // ---------------------------------------------------------------------------
    // Row counter and push strobe
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
            push_q  <= 1'b0;
        end else begin
            push_q <= 1'b0;
            if (row_stb_i) begin
                if (row_cnt == ROW_LAST) begin
                    row_cnt <= '0;
                    push_q  <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    // Block payload, one row per strobe
    always_ff @(posedge clk) begin
        if (row_stb_i) begin
            blk_q[row_cnt] <= row_i;
        end
    end

    // Tag advances once the pushed entry has been taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else if (push_q) begin
            if (tag_q == TAG_LAST) begin
                tag_q <= '0;
            end else begin
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    assign push_o      = push_q;
    assign entry_o.blk = blk_q;
    assign entry_o.idx = tag_q;

endmodule

/* cost_min_select.sv */
// Group minimum selector
// Pops blocks, tracks valid and tag beside the transform, reports each group's winner

`timescale 1ns/100ps

`include "blk_consts.svh"

module cost_min_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_i,
    input  logic                  empty_i,
    input  blk_pkg::blk_entry_t   head_i,
    input  cost_pkg::weight_set_t weights_i,
    output logic                  pop_o,
    output logic                  best_vld_o,
    output blk_pkg::cand_idx_t    best_idx_o,
    output cost_pkg::cost_t       best_cost_o
);

    // Register stages inside hadamard_wcost
    localparam int unsigned PIPE_N = 3;
    localparam blk_pkg::cand_idx_t TAG_LAST = blk_pkg::cand_idx_t'(`BLK_CAND_N - 1);

    logic               pop;
    logic               vld_q [PIPE_N];
    blk_pkg::cand_idx_t tag_q [PIPE_N];
    cost_pkg::cost_t    cost;
    cost_pkg::cost_t    run_cost;
    blk_pkg::cand_idx_t run_idx;
    logic               take;
    cost_pkg::cost_t    new_cost;
    blk_pkg::cand_idx_t new_idx;
    logic               best_vld_q;
    blk_pkg::cand_idx_t best_idx_q;
    cost_pkg::cost_t    best_cost_q;

    // Pop whenever a head exists and the sink is not stalled
    assign pop   = !empty_i && !stall_i;
    assign pop_o = pop;

    hadamard_wcost u_hadamard_wcost (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_i     (head_i.blk),
        .weights_i (weights_i),
        .cost_o    (cost)
    );

    // ---------------------------------------------------------------------------
    // Valid and tag pipeline, aligned with cost
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < PIPE_N; s++) begin
                vld_q[s] <= 1'b0;
                tag_q[s] <= '0;
            end
        end else begin
            vld_q[0] <= pop;
            tag_q[0] <= head_i.idx;
            for (int s = 1; s < PIPE_N; s++) begin
                vld_q[s] <= vld_q[s-1];
                tag_q[s] <= tag_q[s-1];
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Running minimum
    // ---------------------------------------------------------------------------
    // Strict less-than, earlier candidate keeps a tie
    assign take     = (tag_q[PIPE_N-1] == '0) || (cost < run_cost);
    assign new_cost = take ? cost : run_cost;
    assign new_idx  = take ? tag_q[PIPE_N-1] : run_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cost    <= '0;
            run_idx     <= '0;
            best_vld_q  <= 1'b0;
            best_idx_q  <= '0;
            best_cost_q <= '0;
        end else begin
            best_vld_q <= 1'b0;
            if (vld_q[PIPE_N-1]) begin
                run_cost <= new_cost;
                run_idx  <= new_idx;
                // Last candidate closes the group
                if (tag_q[PIPE_N-1] == TAG_LAST) begin
                    best_vld_q  <= 1'b1;
                    best_idx_q  <= new_idx;
                    best_cost_q <= new_cost;
                end
            end
        end
    end

    assign best_vld_o  = best_vld_q;
    assign best_idx_o  = best_idx_q;
    assign best_cost_o = best_cost_q;

endmodule

/* cost_pkg.sv */
// Cost-side types of the block-cost engine
// Weights, transform coefficients, partial products and final costs

package cost_pkg;

    `include "blk_consts.svh"

    typedef logic signed [`BLK_WEIGHT_W-1:0] weight_t;

    // Indexed by coefficient position in raster order
    typedef weight_t [`BLK_N*`BLK_N-1:0] weight_set_t;

    // Hadamard coefficient, 16 * 255 needs 12 bits plus sign
    typedef logic signed [12:0] coef_t;

    // Sum of two weighted coefficients
    typedef logic signed [`BLK_COST_W-1:0] prod_t;

    typedef logic signed [`BLK_COST_W-1:0] cost_t;

endpackage

/* hadamard_wcost.sv */
// Weighted Hadamard cost of a 4x4 block
// Row and column butterflies, then |coef|, paired products and sum in three stages

`timescale 1ns/100ps

`include "blk_consts.svh"

module hadamard_wcost (
    input  logic                  clk,
    input  logic                  rst_n,
    input  blk_pkg::pix_blk_t     blk_i,
    input  cost_pkg::weight_set_t weights_i,
    output cost_pkg::cost_t       cost_o
);

    localparam int unsigned N     = `BLK_N;
    localparam int unsigned POS_N = `BLK_N * `BLK_N;
    localparam int unsigned PAIRS = POS_N / 2;

    cost_pkg::coef_t   pix   [POS_N];
    cost_pkg::weight_t w     [POS_N];
    cost_pkg::coef_t   row_c [POS_N];
    cost_pkg::coef_t   col_c [POS_N];
    cost_pkg::coef_t   abs_q [POS_N];
    cost_pkg::prod_t   prod_q[PAIRS];
    cost_pkg::cost_t   sum_c;
    cost_pkg::cost_t   cost_q;

    // ---------------------------------------------------------------------------
    // Combinational butterflies
    // ---------------------------------------------------------------------------
    for (genvar k = 0; k < POS_N; k++) begin : g_pos
        // Unsigned pixel, zero extended
        assign pix[k] = cost_pkg::coef_t'({1'b0, blk_i[k / N][k % N]});
        assign w[k]   = weights_i[k];
    end

    for (genvar i = 0; i < N; i++) begin : g_bfly
        cost_pkg::coef_t r0, r1, r2, r3;
        cost_pkg::coef_t c0, c1, c2, c3;

        // Row i, horizontal pass
        assign r0 = pix[N*i + 0] + pix[N*i + 2];
        assign r1 = pix[N*i + 1] + pix[N*i + 3];
        assign r2 = pix[N*i + 1] - pix[N*i + 3];
        assign r3 = pix[N*i + 0] - pix[N*i + 2];

        assign row_c[N*i + 0] = r0 + r1;
        assign row_c[N*i + 1] = r3 + r2;
        assign row_c[N*i + 2] = r3 - r2;
        assign row_c[N*i + 3] = r0 - r1;

        // Column i, vertical pass over the row results
        assign c0 = row_c[i + 0] + row_c[i + 8];
        assign c1 = row_c[i + 4] + row_c[i + 12];
        assign c2 = row_c[i + 4] - row_c[i + 12];
        assign c3 = row_c[i + 0] - row_c[i + 8];

        assign col_c[i + 0]  = c0 + c1;
        assign col_c[i + 4]  = c3 + c2;
        assign col_c[i + 8]  = c3 - c2;
        assign col_c[i + 12] = c0 - c1;
    end

    // ---------------------------------------------------------------------------
    // Stage 1, absolute coefficients
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < POS_N; k++) begin
                abs_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < POS_N; k++) begin
                abs_q[k] <= col_c[k][12] ? -col_c[k] : col_c[k];
            end
        end
    end

    // Stage 2, weighted products summed in neighbouring pairs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < PAIRS; j++) begin
                prod_q[j] <= '0;
            end
        end else begin
            for (int j = 0; j < PAIRS; j++) begin
                prod_q[j] <= cost_pkg::prod_t'(abs_q[2*j] * w[2*j])
                           + cost_pkg::prod_t'(abs_q[2*j+1] * w[2*j+1]);
            end
        end
    end

    // Stage 3, total
    always_comb begin
        sum_c = '0;
        for (int j = 0; j < PAIRS; j++) begin
            sum_c = sum_c + prod_q[j];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cost_q <= '0;
        end else begin
            cost_q <= sum_c;
        end
    end

    assign cost_o = cost_q;

endmodule

/* tb_blk_cost_top.sv */
// Testbench for the block-cost engine
// Directed and random groups checked against a model of the weighted Hadamard cost

`timescale 1ns/100ps

`include "blk_consts.svh"

module tb_blk_cost_top;

    localparam int RAND_GROUPS  = 12;
    localparam int STALL_CYCLES = 40;
    // Reset, 15 groups of 16 rows plus drain, stall hold, overflow writes and slack
    localparam int STIM_CYCLES    = 5 + 15 * 24 + STALL_CYCLES + 2 * 16 + 6 * 4 + 20;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  row_stb;
    blk_pkg::pix_row_t     row;
    cost_pkg::weight_set_t weights;
    logic                  stall;
    logic                  blk_full;
    logic                  blk_overflow;
    logic                  best_vld;
    blk_pkg::cand_idx_t    best_idx;
    cost_pkg::cost_t       best_cost;

    blk_pkg::pix_blk_t grp  [`BLK_CAND_N];
    blk_pkg::pix_blk_t held [2 * `BLK_CAND_N];
    int                flat_v [`BLK_CAND_N];
    string             test_name;
    int                exp_idx_q [$];
    cost_pkg::cost_t   exp_cost_q [$];
    string             exp_name_q [$];
    int                errors = 0;
    int                passes = 0;
    int                cycles = 0;
    bit                ovf_allowed = 1'b0;
    bit                ovf_seen = 1'b0;

    blk_cost_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .row_stb_i      (row_stb),
        .row_i          (row),
        .weights_i      (weights),
        .stall_i        (stall),
        .blk_full_o     (blk_full),
        .blk_overflow_o (blk_overflow),
        .best_vld_o     (best_vld),
        .best_idx_o     (best_idx),
        .best_cost_o    (best_cost)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic butterfly(input int x0, input int x1, input int x2, input int x3,
                             output int y0, output int y1, output int y2, output int y3);
        int s02;
        int s13;
        int d02;
        int d13;
        s02 = x0 + x2;
        s13 = x1 + x3;
        d02 = x0 - x2;
        d13 = x1 - x3;
        y0 = s02 + s13;
        y1 = d02 + d13;
        y2 = d02 - d13;
        y3 = s02 - s13;
    endtask

    // Row pass then column pass, |coef| times the weight at that position
    task automatic model_cost(input blk_pkg::pix_blk_t b, output longint cost);
        int p [16];
        int h [16];
        int v [16];
        cost = 0;
        for (int k = 0; k < 16; k++) begin
            p[k] = int'(b[k / 4][k % 4]);
        end
        for (int r = 0; r < 4; r++) begin
            butterfly(p[4*r], p[4*r+1], p[4*r+2], p[4*r+3],
                      h[4*r], h[4*r+1], h[4*r+2], h[4*r+3]);
        end
        for (int c = 0; c < 4; c++) begin
            butterfly(h[c], h[c+4], h[c+8], h[c+12], v[c], v[c+4], v[c+8], v[c+12]);
        end
        for (int k = 0; k < 16; k++) begin
            cost += longint'(v[k] < 0 ? -v[k] : v[k]) * longint'($signed(weights[k]));
        end
    endtask

    task automatic push_expected(input int idx, input longint cost);
        exp_idx_q.push_back(idx);
        exp_cost_q.push_back(cost_pkg::cost_t'(cost));
        exp_name_q.push_back(test_name);
    endtask

    // Strict less-than, so the lower index keeps a tie
    task automatic expect_group();
        longint c;
        longint best_c;
        int     best_i;
        best_c = 0;
        best_i = 0;
        for (int b = 0; b < `BLK_CAND_N; b++) begin
            model_cost(grp[b], c);
            if (b == 0 || c < best_c) begin
                best_c = c;
                best_i = b;
            end
        end
        push_expected(best_i, best_c);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus helpers, all start and end on a falling edge
    // ------------------------------------------------------------------------
    function automatic blk_pkg::pix_blk_t rand_block();
        blk_pkg::pix_blk_t b;
        for (int k = 0; k < 16; k++) begin
            b[k / 4][k % 4] = blk_pkg::pixel_t'($urandom_range(0, 255));
        end
        return b;
    endfunction

    task automatic new_weights();
        for (int k = 0; k < 16; k++) begin
            weights[k] = cost_pkg::weight_t'($urandom_range(0, 65535));
        end
    endtask

    task automatic write_block(input blk_pkg::pix_blk_t b, input bit hold_on_full);
        for (int r = 0; r < `BLK_N; r++) begin
            while (hold_on_full && blk_full) begin
                @(negedge clk);
            end
            row     = b[r];
            row_stb = 1'b1;
            @(negedge clk);
            row_stb = 1'b0;
        end
    endtask

    task automatic run_group();
        for (int b = 0; b < `BLK_CAND_N; b++) begin
            write_block(grp[b], 1'b0);
        end
    endtask

    task automatic wait_drain();
        while (exp_idx_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic check_level(input bit ok, input string what);
        assert (ok) passes++;
        else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    // ------------------------------------------------------------------------
    // Result and flag checks, sampled on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : check_outputs
        int              e_idx;
        cost_pkg::cost_t e_cost;
        string           e_name;
        if (!rst_n) begin
            ovf_seen = 1'b0;
        end else begin
            if (best_vld && exp_idx_q.size() == 0) begin
                errors++;
                $display("Group result with no group outstanding, index %0d cost %0d",
                         best_idx, best_cost);
            end else if (best_vld) begin
                e_idx  = exp_idx_q.pop_front();
                e_cost = exp_cost_q.pop_front();
                e_name = exp_name_q.pop_front();
                assert (best_idx == e_idx) passes++;
                else begin
                    errors++;
                    $display("FAIL %s best_idx expected %0d actual %0d", e_name, e_idx, best_idx);
                end
                assert (best_cost == e_cost) passes++;
                else begin
                    errors++;
                    $display("FAIL %s best_cost expected %0d actual %0d",
                             e_name, e_cost, best_cost);
                end
            end
            assert (ovf_allowed || !blk_overflow)
            else begin
                errors++;
                $display("Overflow flag set although no push could have been dropped");
            end
            assert (!ovf_seen || blk_overflow)
            else begin
                errors++;
                $display("Overflow flag cleared without a reset");
            end
            ovf_seen = ovf_seen | blk_overflow;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d group results outstanding",
                     cycles, exp_idx_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        longint tie_cost;
        void'($urandom(32'h3fd48edc));
        rst_n     = 1'b0;
        row_stb   = 1'b0;
        row       = '0;
        weights   = '0;
        stall     = 1'b0;
        test_name = "reset";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_level(!blk_full && !blk_overflow && !best_vld, "outputs not idle after reset");

        // Flat blocks, only DC is nonzero so cost is 16 * v * w0
        test_name = "flat_blocks";
        new_weights();
        weights[0] = cost_pkg::weight_t'($urandom_range(1, 32767));
        flat_v = '{120, 45, 200, 46};
        for (int b = 0; b < `BLK_CAND_N; b++) begin
            for (int k = 0; k < 16; k++) begin
                grp[b][k / 4][k % 4] = blk_pkg::pixel_t'(flat_v[b]);
            end
        end
        push_expected(1, 16 * 45 * longint'(weights[0]));
        run_group();
        wait_drain();

        test_name = "random_groups";
        for (int g = 0; g < RAND_GROUPS; g++) begin
            new_weights();
            for (int b = 0; b < `BLK_CAND_N; b++) begin
                grp[b] = rand_block();
            end
            expect_group();
            run_group();
            wait_drain();
        end

        test_name = "ties";
        new_weights();
        grp[0] = rand_block();
        for (int b = 1; b < `BLK_CAND_N; b++) begin
            grp[b] = grp[0];
        end
        // Identical blocks, index 0 keeps the tie
        model_cost(grp[0], tie_cost);
        push_expected(0, tie_cost);
        run_group();
        wait_drain();

        // Source honours full while the selector is stalled
        test_name = "stall_backpressure";
        new_weights();
        stall = 1'b1;
        for (int g = 0; g < 2; g++) begin
            for (int b = 0; b < `BLK_CAND_N; b++) begin
                grp[b] = rand_block();
                held[g * `BLK_CAND_N + b] = grp[b];
            end
            expect_group();
        end
        fork
            begin
                for (int k = 0; k < 2 * `BLK_CAND_N; k++) begin
                    write_block(held[k], 1'b1);
                end
            end
            begin
                repeat (STALL_CYCLES) @(negedge clk);
                stall = 1'b0;
            end
        join
        wait_drain();
        check_level(!blk_overflow, "overflow flag set during back-pressure");

        // Source ignores full, the two extra blocks are dropped
        test_name   = "overflow";
        ovf_allowed = 1'b1;
        stall       = 1'b1;
        new_weights();
        for (int b = 0; b < `BLK_CAND_N; b++) begin
            grp[b] = rand_block();
        end
        expect_group();
        run_group();
        @(negedge clk);
        check_level(blk_full && !blk_overflow, "FIFO not full or flag set too early");
        write_block(rand_block(), 1'b0);
        write_block(rand_block(), 1'b0);
        repeat (3) @(negedge clk);
        check_level(blk_overflow, "overflow flag did not rise after pushes into a full FIFO");
        repeat (10) @(negedge clk);
        stall = 1'b0;
        wait_drain();
        check_level(blk_overflow, "overflow flag lost before reset");
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n       = 1'b1;
        ovf_allowed = 1'b0;
        check_level(!blk_full && !blk_overflow && !best_vld, "outputs not idle after reset");

        // Tag restarts at 0 after reset
        test_name = "after_reset";
        new_weights();
        for (int b = 0; b < `BLK_CAND_N; b++) begin
            grp[b] = rand_block();
        end
        expect_group();
        run_group();
        wait_drain();

        $display("Checks passed: %0d, errors: %0d, results outstanding: %0d",
                 passes, errors, exp_idx_q.size());
        if (errors == 0 && passes > 0 && exp_idx_q.size() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
